// File: common/mem_pkg.sv
// memory side definitions shared by both caches, the arbiter and the memory
// the word width is fixed here and every block width is derived from it

package mem_pkg;

	// cpu word width in bits
	localparam int word_bits = 32;

	// operation on the block memory bus
	// op_idle means neither strobe is driven
	typedef enum logic [1:0]
	{
		op_idle,
		op_read,
		op_write
	} mem_op_e;

	// which cache currently holds the block memory
	typedef enum logic [1:0]
	{
		own_none,
		own_icache,
		own_dcache
	} owner_e;

endpackage

// File: common/cache_pkg.sv
// controller states shared by the instruction and data caches
// the icache never enters st_write

package cache_pkg;

	// st_idle    waits for a cpu request and captures it
	// st_lookup  compares the tag of the captured address
	// st_refill  reads the whole block from memory
	// st_write   writes the merged block through to memory
	// st_reply   reply pulse is high, return to idle next
	typedef enum logic [2:0]
	{
		st_idle,
		st_lookup,
		st_refill,
		st_write,
		st_reply
	} cache_state_e;

endpackage

// File: src/block_mem.sv
// slow block memory, contents are undefined until a block is written
// exactly one of ren and wen must be high for an access to proceed

module block_mem
	import mem_pkg::*;
#(
	parameter int block_words = 4,
	parameter int mem_blocks = 64,
	parameter int mem_delay = 2
) (
	input logic clock,
	input logic reset,
	input logic ren,
	input logic wen,
	input logic [$clog2(mem_blocks)-1:0] block_addr,
	input logic [block_words*word_bits-1:0] wdata,
	output logic ready,
	output logic done,
	output logic [block_words*word_bits-1:0] rdata
);

	localparam int blk_w = block_words * word_bits;

	logic [blk_w-1:0] mem [mem_blocks];
	logic [blk_w-1:0] wdata_q;
	logic wdata_held;
	logic [mem_delay-1:0] delay_cnt;
	logic one_req;
	logic delayed;
	logic pulse_rd;
	logic pulse_wr;

	// only a clean read or a clean write lets the counter run
	assign one_req = ren ^ wen;
	assign delayed = &delay_cnt;

	// no pulse while the previous one is still out, the counter clears on it
	assign pulse_rd = delayed && ren && !wen && !ready;
	assign pulse_wr = delayed && wen && !ren && !done;

	// delay counter, saturates at its top value
	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			delay_cnt <= '0;
		end
		else if (!one_req || ready || done)
		begin
			delay_cnt <= '0;
		end
		else if (!delayed)
		begin
			delay_cnt <= delay_cnt + 1'b1;
		end
	end

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			ready <= 1'b0;
			done <= 1'b0;
			wdata_held <= 1'b0;
		end
		else
		begin
			ready <= pulse_rd;
			done <= pulse_wr;
			// write data is taken once per write, again after a done
			wdata_held <= wen && !ren && !done;
		end
	end

	always_ff @(posedge clock)
	begin
		if (wen && !ren && !wdata_held)
		begin
			wdata_q <= wdata;
		end
		if (pulse_wr)
		begin
			mem[block_addr] <= wdata_q;
		end
		// read data appears together with ready
		if (pulse_rd)
		begin
			rdata <= mem[block_addr];
		end
	end

endmodule

// File: src/mem_arbiter.sv
// round-robin owner of the block memory, icache wins the first tie after reset
// a grant lasts until the owner's pulse and is released the cycle after it

module mem_arbiter
	import mem_pkg::*;
#(
	parameter int block_words = 4,
	parameter int mem_blocks = 64
) (
	input logic clock,
	input logic reset,
	input logic ic_ren,
	input logic [$clog2(mem_blocks)-1:0] ic_block_addr,
	input logic dc_ren,
	input logic dc_wen,
	input logic [$clog2(mem_blocks)-1:0] dc_block_addr,
	input logic [block_words*word_bits-1:0] dc_wdata,
	input logic mem_ready,
	input logic mem_done,
	output logic ic_ready,
	output logic dc_ready,
	output logic dc_done,
	output logic mem_ren,
	output logic mem_wen,
	output logic [$clog2(mem_blocks)-1:0] mem_block_addr,
	output logic [block_words*word_bits-1:0] mem_wdata
);

	owner_e grant;
	mem_op_e grant_op;
	logic last_dcache;
	logic dc_req;
	logic pick_dc;

	assign dc_req = dc_ren || dc_wen;
	// dcache wins when alone or when icache was served last
	assign pick_dc = dc_req && (!ic_ren || !last_dcache);

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			grant <= own_none;
			grant_op <= op_idle;
			last_dcache <= 1'b1;
		end
		else if (grant != own_none)
		begin
			if (mem_ready || mem_done)
			begin
				grant <= own_none;
				grant_op <= op_idle;
			end
		end
		else if (pick_dc)
		begin
			grant <= own_dcache;
			grant_op <= dc_wen ? op_write : op_read;
			last_dcache <= 1'b1;
		end
		else if (ic_ren)
		begin
			grant <= own_icache;
			grant_op <= op_read;
			last_dcache <= 1'b0;
		end
	end

	// only the strobe of the granted operation reaches the memory
	assign mem_ren = (grant_op == op_read);
	assign mem_wen = (grant_op == op_write);
	assign mem_block_addr = (grant == own_dcache) ? dc_block_addr : ic_block_addr;
	assign mem_wdata = dc_wdata;

	// pulses go back to the owner only
	assign ic_ready = (grant == own_icache) && mem_ready;
	assign dc_ready = (grant == own_dcache) && mem_ready;
	assign dc_done = (grant == own_dcache) && mem_done;

endmodule

// File: icache/icache.sv
// direct-mapped read-only instruction cache, not coherent with the dcache
// block_words and icache_lines are powers of two, block_words at least 2

module icache
	import mem_pkg::*, cache_pkg::*;
#(
	parameter int block_words = 4,
	parameter int icache_lines = 4,
	parameter int mem_blocks = 64
) (
	input logic clock,
	input logic reset,
	input logic fetch_en,
	input logic [$clog2(mem_blocks*block_words)-1:0] fetch_addr,
	input logic mem_ready,
	input logic [block_words*word_bits-1:0] mem_rdata,
	output logic fetch_valid,
	output logic [word_bits-1:0] fetch_data,
	output logic mem_ren,
	output logic [$clog2(mem_blocks)-1:0] mem_block_addr
);

	localparam int off_bits = $clog2(block_words);
	localparam int idx_bits = $clog2(icache_lines);
	localparam int blk_bits = $clog2(mem_blocks);
	localparam int tag_bits = blk_bits - idx_bits;
	localparam int addr_bits = blk_bits + off_bits;
	localparam int blk_w = block_words * word_bits;

	cache_state_e state;
	mem_op_e mem_op;
	logic [addr_bits-1:0] req_addr;
	logic [icache_lines-1:0] line_valid;
	logic [tag_bits-1:0] line_tag [icache_lines];
	logic [blk_w-1:0] line_data [icache_lines];
	logic [off_bits-1:0] req_off;
	logic [idx_bits-1:0] req_idx;
	logic [tag_bits-1:0] req_tag;
	logic lookup_hit;
	logic refill_done;

	// word offset, line index and tag of the captured fetch address
	assign req_off = req_addr[off_bits-1:0];
	assign req_idx = req_addr[off_bits +: idx_bits];
	assign req_tag = req_addr[addr_bits-1 -: tag_bits];
	assign lookup_hit = (state == st_lookup) && line_valid[req_idx]
		&& (line_tag[req_idx] == req_tag);
	assign refill_done = (state == st_refill) && mem_ready;

	// held stable from the miss until ready
	assign mem_ren = (mem_op == op_read);
	assign mem_block_addr = req_addr[addr_bits-1:off_bits];

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			state <= st_idle;
			mem_op <= op_idle;
			fetch_valid <= 1'b0;
			line_valid <= '0;
		end
		else
		begin
			fetch_valid <= 1'b0;
			case (state)
				st_idle:
				begin
					if (fetch_en)
						state <= st_lookup;
				end
				st_lookup:
				begin
					if (lookup_hit)
					begin
						fetch_valid <= 1'b1;
						state <= st_reply;
					end
					else
					begin
						mem_op <= op_read;
						state <= st_refill;
					end
				end
				st_refill:
				begin
					if (mem_ready)
					begin
						mem_op <= op_idle;
						line_valid[req_idx] <= 1'b1;
						fetch_valid <= 1'b1;
						state <= st_reply;
					end
				end
				// reply cycle, the cpu drops fetch_en after it
				default:
					state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if ((state == st_idle) && fetch_en)
			req_addr <= fetch_addr;
		if (lookup_hit)
			fetch_data <= line_data[req_idx][req_off*word_bits +: word_bits];
		if (refill_done)
		begin
			line_tag[req_idx] <= req_tag;
			line_data[req_idx] <= mem_rdata;
			// requested word straight from the refill data
			fetch_data <= mem_rdata[req_off*word_bits +: word_bits];
		end
	end

endmodule

// File: dcache/dcache.sv
// direct-mapped write-through data cache, every store writes its whole block
// block_words and dcache_lines are powers of two, block_words at least 2

module dcache
	import mem_pkg::*, cache_pkg::*;
#(
	parameter int block_words = 4,
	parameter int dcache_lines = 4,
	parameter int mem_blocks = 64
) (
	input logic clock,
	input logic reset,
	input logic load_en,
	input logic store_en,
	input logic [$clog2(mem_blocks*block_words)-1:0] data_addr,
	input logic [word_bits-1:0] store_data,
	input logic mem_ready,
	input logic mem_done,
	input logic [block_words*word_bits-1:0] mem_rdata,
	output logic load_valid,
	output logic [word_bits-1:0] load_data,
	output logic store_done,
	output logic mem_ren,
	output logic mem_wen,
	output logic [$clog2(mem_blocks)-1:0] mem_block_addr,
	output logic [block_words*word_bits-1:0] mem_wdata
);

	localparam int off_bits = $clog2(block_words);
	localparam int idx_bits = $clog2(dcache_lines);
	localparam int blk_bits = $clog2(mem_blocks);
	localparam int tag_bits = blk_bits - idx_bits;
	localparam int addr_bits = blk_bits + off_bits;
	localparam int blk_w = block_words * word_bits;

	cache_state_e state;
	mem_op_e mem_op;
	logic [addr_bits-1:0] req_addr;
	logic [word_bits-1:0] req_wdata;
	logic req_store;
	logic [dcache_lines-1:0] line_valid;
	logic [tag_bits-1:0] line_tag [dcache_lines];
	logic [blk_w-1:0] line_data [dcache_lines];
	logic [off_bits-1:0] req_off;
	logic [idx_bits-1:0] req_idx;
	logic [tag_bits-1:0] req_tag;
	logic lookup_hit;
	logic refill_done;
	logic [blk_w-1:0] hit_block;
	logic [blk_w-1:0] fill_block;

	// replace one word of a block
	function automatic logic [blk_w-1:0] merge_word(
		input logic [blk_w-1:0] blk,
		input logic [off_bits-1:0] off,
		input logic [word_bits-1:0] word
	);
		logic [blk_w-1:0] merged;
		merged = blk;
		merged[off*word_bits +: word_bits] = word;
		return merged;
	endfunction

	assign req_off = req_addr[off_bits-1:0];
	assign req_idx = req_addr[off_bits +: idx_bits];
	assign req_tag = req_addr[addr_bits-1 -: tag_bits];
	assign lookup_hit = (state == st_lookup) && line_valid[req_idx]
		&& (line_tag[req_idx] == req_tag);
	assign refill_done = (state == st_refill) && mem_ready;

	// store data merged into the line on a hit, or into the refill block
	assign hit_block = merge_word(line_data[req_idx], req_off, req_wdata);
	assign fill_block = req_store ? merge_word(mem_rdata, req_off, req_wdata) : mem_rdata;

	assign mem_ren = (mem_op == op_read);
	assign mem_wen = (mem_op == op_write);
	assign mem_block_addr = req_addr[addr_bits-1:off_bits];

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			state <= st_idle;
			mem_op <= op_idle;
			load_valid <= 1'b0;
			store_done <= 1'b0;
			line_valid <= '0;
		end
		else
		begin
			load_valid <= 1'b0;
			store_done <= 1'b0;
			case (state)
				st_idle:
				begin
					if (load_en || store_en)
						state <= st_lookup;
				end
				st_lookup:
				begin
					if (!lookup_hit)
					begin
						mem_op <= op_read;
						state <= st_refill;
					end
					else if (req_store)
					begin
						mem_op <= op_write;
						state <= st_write;
					end
					else
					begin
						load_valid <= 1'b1;
						state <= st_reply;
					end
				end
				st_refill:
				begin
					if (mem_ready)
					begin
						line_valid[req_idx] <= 1'b1;
						if (req_store)
						begin
							// a store goes straight on to the write-through
							mem_op <= op_write;
							state <= st_write;
						end
						else
						begin
							mem_op <= op_idle;
							load_valid <= 1'b1;
							state <= st_reply;
						end
					end
				end
				st_write:
				begin
					if (mem_done)
					begin
						mem_op <= op_idle;
						store_done <= 1'b1;
						state <= st_reply;
					end
				end
				default:
					state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if ((state == st_idle) && (load_en || store_en))
		begin
			req_addr <= data_addr;
			req_store <= store_en;
			req_wdata <= store_data;
		end
		if (lookup_hit && req_store)
		begin
			line_data[req_idx] <= hit_block;
			mem_wdata <= hit_block;
		end
		if (lookup_hit && !req_store)
			load_data <= line_data[req_idx][req_off*word_bits +: word_bits];
		if (refill_done)
		begin
			line_tag[req_idx] <= req_tag;
			line_data[req_idx] <= fill_block;
			mem_wdata <= fill_block;
			load_data <= mem_rdata[req_off*word_bits +: word_bits];
		end
	end

endmodule

// File: src/mem_subsystem.sv
// icache and dcache sharing one block memory through a round-robin arbiter
// memory is not preloaded, blocks must be stored before they are read

module mem_subsystem
	import mem_pkg::*;
#(
	parameter int block_words = 4,
	parameter int mem_blocks = 64,
	parameter int mem_delay = 2,
	parameter int icache_lines = 4,
	parameter int dcache_lines = 4
) (
	input logic clock,
	input logic reset,
	// instruction fetch port
	input logic fetch_en,
	input logic [$clog2(mem_blocks*block_words)-1:0] fetch_addr,
	output logic fetch_valid,
	output logic [word_bits-1:0] fetch_data,
	// data port
	input logic load_en,
	input logic store_en,
	input logic [$clog2(mem_blocks*block_words)-1:0] data_addr,
	input logic [word_bits-1:0] store_data,
	output logic load_valid,
	output logic [word_bits-1:0] load_data,
	output logic store_done
);

	localparam int blk_bits = $clog2(mem_blocks);
	localparam int blk_w = block_words * word_bits;

	// cache side of the arbiter
	logic ic_ren;
	logic ic_ready;
	logic [blk_bits-1:0] ic_block_addr;
	logic dc_ren;
	logic dc_wen;
	logic dc_ready;
	logic dc_done;
	logic [blk_bits-1:0] dc_block_addr;
	logic [blk_w-1:0] dc_wdata;

	// memory side, read data is shared by both caches
	logic mem_ren;
	logic mem_wen;
	logic mem_ready;
	logic mem_done;
	logic [blk_bits-1:0] mem_block_addr;
	logic [blk_w-1:0] mem_wdata;
	logic [blk_w-1:0] mem_rdata;

	icache #(
		.block_words(block_words),
		.icache_lines(icache_lines),
		.mem_blocks(mem_blocks)
	) i_icache (
		.clock(clock),
		.reset(reset),
		.fetch_en(fetch_en),
		.fetch_addr(fetch_addr),
		.mem_ready(ic_ready),
		.mem_rdata(mem_rdata),
		.fetch_valid(fetch_valid),
		.fetch_data(fetch_data),
		.mem_ren(ic_ren),
		.mem_block_addr(ic_block_addr)
	);

	dcache #(
		.block_words(block_words),
		.dcache_lines(dcache_lines),
		.mem_blocks(mem_blocks)
	) i_dcache (
		.clock(clock),
		.reset(reset),
		.load_en(load_en),
		.store_en(store_en),
		.data_addr(data_addr),
		.store_data(store_data),
		.mem_ready(dc_ready),
		.mem_done(dc_done),
		.mem_rdata(mem_rdata),
		.load_valid(load_valid),
		.load_data(load_data),
		.store_done(store_done),
		.mem_ren(dc_ren),
		.mem_wen(dc_wen),
		.mem_block_addr(dc_block_addr),
		.mem_wdata(dc_wdata)
	);

	mem_arbiter #(
		.block_words(block_words),
		.mem_blocks(mem_blocks)
	) i_arbiter (
		.clock(clock),
		.reset(reset),
		.ic_ren(ic_ren),
		.ic_block_addr(ic_block_addr),
		.dc_ren(dc_ren),
		.dc_wen(dc_wen),
		.dc_block_addr(dc_block_addr),
		.dc_wdata(dc_wdata),
		.mem_ready(mem_ready),
		.mem_done(mem_done),
		.ic_ready(ic_ready),
		.dc_ready(dc_ready),
		.dc_done(dc_done),
		.mem_ren(mem_ren),
		.mem_wen(mem_wen),
		.mem_block_addr(mem_block_addr),
		.mem_wdata(mem_wdata)
	);

	block_mem #(
		.block_words(block_words),
		.mem_blocks(mem_blocks),
		.mem_delay(mem_delay)
	) i_block_mem (
		.clock(clock),
		.reset(reset),
		.ren(mem_ren),
		.wen(mem_wen),
		.block_addr(mem_block_addr),
		.wdata(mem_wdata),
		.ready(mem_ready),
		.done(mem_done),
		.rdata(mem_rdata)
	);

endmodule

// File: tests/tb_clock_gen.sv
// free-running clock and active-low reset for the testbench
// reset is released on a falling edge, clear of the rising edge

module tb_clock_gen #(
	parameter int period = 8,
	parameter int reset_cycles = 8
) (
	output logic clock,
	output logic reset
);

	initial
	begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

	initial
	begin
		reset = 1'b0;
		repeat (reset_cycles) @(posedge clock);
		@(negedge clock);
		reset = 1'b1;
	end

endmodule

// File: tests/mem_subsystem_chk.sv
// protocol assertions on the cpu ports and the block memory bus
// all checks are idle while reset is low

module mem_subsystem_chk
	import mem_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic fetch_en,
	input logic fetch_valid,
	input logic load_en,
	input logic store_en,
	input logic load_valid,
	input logic store_done,
	input logic mem_ren,
	input logic mem_wen,
	input logic mem_ready,
	input logic mem_done,
	input owner_e grant
);

	// number of failed assertions
	int fail_count = 0;

	// memory sees a clean read or a clean write
	mem_one_op: assert property (@(posedge clock) disable iff (!reset)
		!(mem_ren && mem_wen))
		else
		begin
			fail_count++;
			$error("mem_ren and mem_wen are high together");
		end

	// cpu side never loads and stores at once
	cpu_one_op: assert property (@(posedge clock) disable iff (!reset)
		!(load_en && store_en))
		else
		begin
			fail_count++;
			$error("load_en and store_en are high together");
		end

	// reply pulses are one cycle wide
	fetch_pulse: assert property (@(posedge clock) disable iff (!reset)
		fetch_valid |=> !fetch_valid)
		else
		begin
			fail_count++;
			$error("fetch_valid stayed high for more than one cycle");
		end
	load_pulse: assert property (@(posedge clock) disable iff (!reset)
		load_valid |=> !load_valid)
		else
		begin
			fail_count++;
			$error("load_valid stayed high for more than one cycle");
		end
	store_pulse: assert property (@(posedge clock) disable iff (!reset)
		store_done |=> !store_done)
		else
		begin
			fail_count++;
			$error("store_done stayed high for more than one cycle");
		end

	// a reply only answers a request that is still held
	fetch_held: assert property (@(posedge clock) disable iff (!reset)
		fetch_valid |-> fetch_en)
		else
		begin
			fail_count++;
			$error("fetch_valid pulsed without fetch_en");
		end
	load_held: assert property (@(posedge clock) disable iff (!reset)
		load_valid |-> load_en)
		else
		begin
			fail_count++;
			$error("load_valid pulsed without load_en");
		end
	store_held: assert property (@(posedge clock) disable iff (!reset)
		store_done |-> store_en)
		else
		begin
			fail_count++;
			$error("store_done pulsed without store_en");
		end

	// memory pulses only come back to a granted cache
	pulse_owned: assert property (@(posedge clock) disable iff (!reset)
		(mem_ready || mem_done) |-> (grant != own_none))
		else
		begin
			fail_count++;
			$error("memory pulse while the arbiter has no owner");
		end

endmodule

bind mem_subsystem mem_subsystem_chk i_chk (
	.clock(clock),
	.reset(reset),
	.fetch_en(fetch_en),
	.fetch_valid(fetch_valid),
	.load_en(load_en),
	.store_en(store_en),
	.load_valid(load_valid),
	.store_done(store_done),
	.mem_ren(mem_ren),
	.mem_wen(mem_wen),
	.mem_ready(mem_ready),
	.mem_done(mem_done),
	.grant(i_arbiter.grant)
);

// File: tests/tb_mem_subsystem.sv
// table-driven test of the memory subsystem, expected words come from a word model
// memory starts undefined, so the table stores every block before reading it

module tb_mem_subsystem
	import mem_pkg::*;
();

	localparam int block_words = 4;
	localparam int mem_delay = 2;
	localparam int addr_bits = 8;
	localparam int hit_cycles = 2;
	// blocks written by the store phase, later reads stay inside them
	localparam int used_blocks = 12;

	typedef enum {row_quiet, row_store, row_load, row_fetch, row_dual} row_kind_e;

	logic clock;
	logic reset;
	logic fetch_en;
	logic [addr_bits-1:0] fetch_addr;
	logic fetch_valid;
	logic [word_bits-1:0] fetch_data;
	logic load_en;
	logic store_en;
	logic [addr_bits-1:0] data_addr;
	logic [word_bits-1:0] store_data;
	logic load_valid;
	logic [word_bits-1:0] load_data;
	logic store_done;

	// stimulus table, one entry per row in each queue
	row_kind_e row_kind[$];
	logic [addr_bits-1:0] row_addr[$];
	logic [addr_bits-1:0] row_faddr[$];
	logic [word_bits-1:0] row_data[$];
	logic [word_bits-1:0] row_exp[$];
	logic [word_bits-1:0] row_fexp[$];
	bit row_hit[$];
	string row_name[$];

	// word model of memory, updated by every store row
	logic [word_bits-1:0] model [1 << addr_bits];
	logic [31:0] lfsr_state;
	int error_count = 0;
	int check_count = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	tb_clock_gen #(.period(8), .reset_cycles(8)) i_clock_gen (.clock(clock), .reset(reset));

	mem_subsystem i_dut (
		.clock(clock),
		.reset(reset),
		.fetch_en(fetch_en),
		.fetch_addr(fetch_addr),
		.fetch_valid(fetch_valid),
		.fetch_data(fetch_data),
		.load_en(load_en),
		.store_en(store_en),
		.data_addr(data_addr),
		.store_data(store_data),
		.load_valid(load_valid),
		.load_data(load_data),
		.store_done(store_done)
	);

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one step for every bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int k = 0; k < n; k++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	// pattern uses every address bit
	function automatic logic [word_bits-1:0] fill_word(input logic [addr_bits-1:0] a);
		return {8'h5a, a, 8'hc3, ~a};
	endfunction

	task automatic add_row(input row_kind_e kind, input logic [addr_bits-1:0] addr,
		input logic [addr_bits-1:0] faddr, input logic [word_bits-1:0] data,
		input bit hit, input string name);
		row_kind.push_back(kind);
		row_addr.push_back(addr);
		row_faddr.push_back(faddr);
		row_data.push_back(data);
		// expected words as the model stands at this row
		row_exp.push_back(model[addr]);
		row_fexp.push_back(model[faddr]);
		row_hit.push_back(hit);
		row_name.push_back(name);
		if (kind == row_store)
			model[addr] = data;
	endtask

	task automatic build_table();
		logic [addr_bits-1:0] a;
		logic [addr_bits-1:0] f;
		add_row(row_quiet, 0, 0, 0, 1'b0, "reset_quiet");
		for (int i = 0; i < used_blocks * block_words; i++)
		begin
			a = i;
			add_row(row_store, a, 0, fill_word(a), 1'b0, $sformatf("store_%0h", a));
		end
		// 12 blocks through 4 dcache lines, word 0 may miss, the rest hit
		for (int i = 0; i < used_blocks * block_words; i++)
		begin
			a = i;
			add_row(row_load, a, 0, 0, (i % block_words) != 0, $sformatf("load_%0h", a));
		end
		// word 2 right after word 0 of the same block hits in the icache
		for (int b = 0; b < 6; b++)
		begin
			f = b * block_words;
			add_row(row_fetch, 0, f, 0, 1'b0, $sformatf("fetch_%0h", f));
			f = f + 2;
			add_row(row_fetch, 0, f, 0, 1'b1, $sformatf("fetch_hit_%0h", f));
		end
		// fetch and load in the same cycle, the arbiter picks the order
		for (int i = 0; i < 8; i++)
		begin
			a = take_bits(addr_bits) % (used_blocks * block_words);
			f = take_bits(addr_bits) % (used_blocks * block_words);
			add_row(row_dual, a, f, 0, 1'b0, $sformatf("dual_%0h_%0h", a, f));
		end
		// block 10 leaves the icache through block 6, then changes in the dcache only
		add_row(row_fetch, 0, 8'h29, 0, 1'b0, "fetch_old_29");
		add_row(row_fetch, 0, 8'h19, 0, 1'b0, "evict_icache_19");
		add_row(row_load, 8'h29, 0, 0, 1'b0, "load_old_29");
		add_row(row_store, 8'h29, 0, ~fill_word(8'h29), 1'b0, "store_new_29");
		add_row(row_load, 8'h29, 0, 0, 1'b1, "load_new_29");
		// icache misses, so the word comes from memory
		add_row(row_fetch, 0, 8'h29, 0, 1'b0, "fetch_new_29");
	endtask

	task automatic check_word(input string name, input logic [word_bits-1:0] exp,
		input logic [word_bits-1:0] act);
		check_count++;
		assert (act === exp) else
		begin
			error_count++;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_latency(input string name, input int waited);
		check_count++;
		assert (waited == hit_cycles) else
		begin
			error_count++;
			$display("Fail %s latency: expected %0d, actual %0d", name, hit_cycles, waited);
		end
	endtask

	// drive on the falling edge, drop each request in the cycle after its pulse
	task automatic apply_row(input int i);
		bit fetch_busy;
		bit data_busy;
		bit fetch_drop;
		bit data_drop;
		int waited;
		fetch_drop = 1'b0;
		data_drop = 1'b0;
		waited = 0;
		fetch_busy = row_kind[i] inside {row_fetch, row_dual};
		data_busy = row_kind[i] inside {row_store, row_load, row_dual};
		if (row_kind[i] == row_quiet)
		begin
			repeat (10)
			begin
				@(negedge clock);
				check_count++;
				assert (!fetch_valid && !load_valid && !store_done) else
				begin
					error_count++;
					$display("Fail %s: expected 000, actual %b%b%b", row_name[i],
						fetch_valid, load_valid, store_done);
				end
			end
		end
		else
		begin
			fetch_en = fetch_busy;
			fetch_addr = row_faddr[i];
			load_en = row_kind[i] inside {row_load, row_dual};
			store_en = (row_kind[i] == row_store);
			data_addr = row_addr[i];
			store_data = row_data[i];
			while (fetch_busy || data_busy)
			begin
				@(negedge clock);
				waited++;
				if (fetch_drop)
				begin
					fetch_en = 1'b0;
					fetch_busy = 1'b0;
					fetch_drop = 1'b0;
				end
				else if (fetch_busy && fetch_valid)
				begin
					fetch_drop = 1'b1;
					check_word(row_name[i], row_fexp[i], fetch_data);
					if (row_hit[i])
						check_latency(row_name[i], waited);
				end
				if (data_drop)
				begin
					load_en = 1'b0;
					store_en = 1'b0;
					data_busy = 1'b0;
					data_drop = 1'b0;
				end
				else if (data_busy && ((load_en && load_valid) || (store_en && store_done)))
				begin
					data_drop = 1'b1;
					if (load_en)
						check_word(row_name[i], row_exp[i], load_data);
					if (row_hit[i])
						check_latency(row_name[i], waited);
				end
			end
		end
	endtask

	// run limit scales with the table length
	always @(posedge clock)
	begin
		cycle_count++;
		if ((cycle_limit > 0) && (cycle_count > cycle_limit))
		begin
			error_count++;
			error_count += i_dut.i_chk.fail_count;
			$display("Timeout: the DUT did not finish the table within %0d cycles", cycle_limit);
			$display("errors: %0d, checks: %0d", error_count, check_count);
			$display("Checks failed");
			$finish;
		end
	end

	initial
	begin
		fetch_en = 1'b0;
		fetch_addr = '0;
		load_en = 1'b0;
		store_en = 1'b0;
		data_addr = '0;
		store_data = '0;
		lfsr_state = 32'hf17f_e66b;
		build_table();
		cycle_limit = row_kind.size() * 4 * ((1 << mem_delay) + 3) + 200;
		wait (reset === 1'b1);
		@(negedge clock);
		for (int i = 0; i < row_kind.size(); i++)
		begin
			apply_row(i);
			@(negedge clock);
		end
		// protocol assertions of the bound checker count as errors too
		error_count += i_dut.i_chk.fail_count;
		$display("errors: %0d, checks: %0d", error_count, check_count);
		if (error_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: flist.f
common/mem_pkg.sv
common/cache_pkg.sv
src/block_mem.sv
src/mem_arbiter.sv
icache/icache.sv
dcache/dcache.sv
src/mem_subsystem.sv
tests/tb_clock_gen.sv
tests/mem_subsystem_chk.sv
tests/tb_mem_subsystem.sv

// File: Bender.yml
package:
  name: mem_subsystem

sources:
  - common/mem_pkg.sv
  - common/cache_pkg.sv
  - src/block_mem.sv
  - src/mem_arbiter.sv
  - icache/icache.sv
  - dcache/dcache.sv
  - src/mem_subsystem.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/mem_subsystem_chk.sv
      - tests/tb_mem_subsystem.sv
